// ==== include/rename_defines.svh ====
`ifndef RENAME_DEFINES_SVH
`define RENAME_DEFINES_SVH

// Group and port widths.
`define RN_WIDTH        2
`define RN_COMMIT_WIDTH 2
`define RN_NUM_SRCS     2

// Register file sizes.
`define RN_NUM_LREG     32
`define RN_NUM_PREG     64
`define RN_LREG_W       5
`define RN_PREG_W       6

// Free list holds the physical registers beyond the logical set.
`define RN_FL_DEPTH     32
`define RN_FL_PTR_W     6   // Index bits plus a wrap bit.

// Opaque decode tag carried through rename.
`define RN_TAG_W        8

`endif

// ==== hdl/rename_pkg.sv ====
`default_nettype none

`include "rename_defines.svh"

package rename_pkg;

    typedef logic [`RN_LREG_W-1:0] lreg_t;  // Logical register index.
    typedef logic [`RN_PREG_W-1:0] preg_t;  // Physical register index.

    // Micro-op as it leaves decode.
    typedef struct packed {
        logic [`RN_TAG_W-1:0]     tag;
        logic                     rd_wen;
        lreg_t                    lrd;
        lreg_t [`RN_NUM_SRCS-1:0] lrs;
    } dec_uop_t;

    // Micro-op handed to dispatch.
    typedef struct packed {
        logic [`RN_TAG_W-1:0]     tag;
        logic                     rd_wen;
        lreg_t                    lrd;
        preg_t                    prd;       // New destination.
        preg_t                    prev_prd;  // Mapping replaced by prd.
        preg_t [`RN_NUM_SRCS-1:0] prs;
    } renamed_uop_t;

    // Destination information of a retiring micro-op.
    typedef struct packed {
        logic  rd_wen;
        lreg_t lrd;
        preg_t prd;
        preg_t prev_prd;
    } commit_info_t;

endpackage

`default_nettype wire

// ==== hdl/rename_free_list.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_free_list (
    input  wire                                             clk,
    input  wire                                             i_arst_n,
    input  wire  [`RN_WIDTH-1:0]                            i_alloc,
    input  wire  [`RN_COMMIT_WIDTH-1:0]                     i_commit_vld,
    input  wire  rename_pkg::commit_info_t [`RN_COMMIT_WIDTH-1:0] i_commit_info,
    input  wire                                             i_squash,
    output rename_pkg::preg_t [`RN_WIDTH-1:0]               o_alloc_prd,
    output logic                                            o_can_alloc
);
    localparam int IDX_W = `RN_FL_PTR_W - 1;

    typedef logic [`RN_FL_PTR_W-1:0] ptr_t;

    rename_pkg::preg_t fl_mem [`RN_FL_DEPTH];

    ptr_t head;      // Speculative head.
    ptr_t cmt_head;  // Head as seen by committed allocations.
    ptr_t tail;
    ptr_t head_nxt;
    ptr_t cmt_head_nxt;
    ptr_t tail_nxt;
    ptr_t free_cnt;

    logic [`RN_COMMIT_WIDTH-1:0] push_en;
    ptr_t                        push_ptr [`RN_COMMIT_WIDTH];

    assign free_cnt    = tail - head;
    assign o_can_alloc = free_cnt >= ptr_t'(`RN_WIDTH);

    // Allocating slots take consecutive entries, lower slot first.
    always_comb begin
        ptr_t rd_ptr;
        rd_ptr = head;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            o_alloc_prd[s] = fl_mem[rd_ptr[IDX_W-1:0]];
            if (i_alloc[s]) begin
                rd_ptr = rd_ptr + 1'b1;
            end
        end
        head_nxt = rd_ptr;
    end

    always_comb begin
        ptr_t wr_ptr;
        wr_ptr = tail;
        for (int c = 0; c < `RN_COMMIT_WIDTH; c++) begin
            push_en[c]  = i_commit_vld[c] && i_commit_info[c].rd_wen &&
                          (i_commit_info[c].lrd != '0);
            push_ptr[c] = wr_ptr;
            if (push_en[c]) begin
                wr_ptr = wr_ptr + 1'b1;
            end
        end
        tail_nxt     = wr_ptr;
        cmt_head_nxt = cmt_head + (wr_ptr - tail);  // One entry per counted commit.
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head     <= '0;
            cmt_head <= '0;
            tail     <= ptr_t'(`RN_FL_DEPTH);  // Full.
        end else begin
            head     <= i_squash ? cmt_head_nxt : head_nxt;
            cmt_head <= cmt_head_nxt;
            tail     <= tail_nxt;
        end
    end

    // Starts with the registers above the logical range.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int e = 0; e < `RN_FL_DEPTH; e++) begin
                fl_mem[e] <= rename_pkg::preg_t'(`RN_NUM_LREG + e);
            end
        end else begin
            for (int c = 0; c < `RN_COMMIT_WIDTH; c++) begin
                if (push_en[c]) begin
                    fl_mem[push_ptr[c][IDX_W-1:0]] <= i_commit_info[c].prev_prd;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_map_table (
    input  wire                                             clk,
    input  wire                                             i_arst_n,
    input  wire  [`RN_WIDTH-1:0]                            i_alloc,
    input  wire  rename_pkg::lreg_t [`RN_WIDTH-1:0]         i_lrd,
    input  wire  rename_pkg::preg_t [`RN_WIDTH-1:0]         i_new_prd,
    input  wire  rename_pkg::lreg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] i_lrs,
    input  wire  [`RN_COMMIT_WIDTH-1:0]                     i_commit_vld,
    input  wire  rename_pkg::commit_info_t [`RN_COMMIT_WIDTH-1:0] i_commit_info,
    input  wire                                             i_squash,
    output rename_pkg::preg_t [`RN_WIDTH-1:0]               o_prev_prd,
    output rename_pkg::preg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] o_prs
);
    rename_pkg::preg_t spec_map [`RN_NUM_LREG];  // Speculative alias table.
    rename_pkg::preg_t cmt_map  [`RN_NUM_LREG];  // Committed alias table.
    rename_pkg::preg_t cmt_nxt  [`RN_NUM_LREG];

    // Reads, with forwarding from earlier slots of the same group.
    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            o_prev_prd[s] = spec_map[i_lrd[s]];
            for (int k = 0; k < `RN_NUM_SRCS; k++) begin
                o_prs[s][k] = spec_map[i_lrs[s][k]];
            end

            // Later writers override earlier ones.
            for (int j = 0; j < s; j++) begin
                if (i_alloc[j] && (i_lrd[j] == i_lrd[s])) begin
                    o_prev_prd[s] = i_new_prd[j];
                end
                for (int k = 0; k < `RN_NUM_SRCS; k++) begin
                    if (i_alloc[j] && (i_lrd[j] == i_lrs[s][k])) begin
                        o_prs[s][k] = i_new_prd[j];
                    end
                end
            end
        end
    end

    // Committed table after this cycle's commits, in slot order.
    always_comb begin
        cmt_nxt = cmt_map;
        for (int c = 0; c < `RN_COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c] && i_commit_info[c].rd_wen &&
                (i_commit_info[c].lrd != '0)) begin
                cmt_nxt[i_commit_info[c].lrd] = i_commit_info[c].prd;
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int l = 0; l < `RN_NUM_LREG; l++) begin
                cmt_map[l] <= rename_pkg::preg_t'(l);  // Identity map.
            end
        end else begin
            cmt_map <= cmt_nxt;
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int l = 0; l < `RN_NUM_LREG; l++) begin
                spec_map[l] <= rename_pkg::preg_t'(l);
            end
        end else if (i_squash) begin
            spec_map <= cmt_nxt;  // Restore.
        end else begin
            // Slot 1 wins when both slots write the same register.
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (i_alloc[s]) begin
                    spec_map[i_lrd[s]] <= i_new_prd[s];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hdl/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_stage (
    input  wire                                             clk,
    input  wire                                             i_arst_n,
    input  wire  [`RN_WIDTH-1:0]                            i_dec_vld,
    input  wire  rename_pkg::dec_uop_t [`RN_WIDTH-1:0]      i_dec_uop,
    input  wire                                             i_stall,
    input  wire                                             i_squash,
    input  wire                                             i_can_alloc,
    input  wire  rename_pkg::preg_t [`RN_WIDTH-1:0]         i_new_prd,
    input  wire  rename_pkg::preg_t [`RN_WIDTH-1:0]         i_prev_prd,
    input  wire  rename_pkg::preg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] i_prs,
    output logic                                            o_stall,
    output logic [`RN_WIDTH-1:0]                            o_alloc,
    output rename_pkg::lreg_t [`RN_WIDTH-1:0]               o_lrd,
    output rename_pkg::lreg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] o_lrs,
    output logic [`RN_WIDTH-1:0]                            o_ren_vld,
    output rename_pkg::renamed_uop_t [`RN_WIDTH-1:0]        o_ren_uop
);
    logic                                     can_rename;
    logic                                     accept;
    logic [`RN_WIDTH-1:0]                     ren_vld;
    rename_pkg::renamed_uop_t [`RN_WIDTH-1:0] ren_nxt;
    rename_pkg::renamed_uop_t [`RN_WIDTH-1:0] ren_uop;

    assign can_rename = i_can_alloc;  // Enough free registers for a full group.
    assign o_stall    = !can_rename || i_stall;
    assign accept     = !o_stall && !i_squash;

    // Register zero is never renamed.
    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            o_lrd[s]   = i_dec_uop[s].lrd;
            o_lrs[s]   = i_dec_uop[s].lrs;
            o_alloc[s] = accept && i_dec_vld[s] && i_dec_uop[s].rd_wen &&
                         (i_dec_uop[s].lrd != '0);
        end
    end

    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            ren_nxt[s].tag      = i_dec_uop[s].tag;
            ren_nxt[s].rd_wen   = i_dec_uop[s].rd_wen;
            ren_nxt[s].lrd      = i_dec_uop[s].lrd;
            ren_nxt[s].prd      = o_alloc[s] ? i_new_prd[s] : '0;
            ren_nxt[s].prev_prd = i_prev_prd[s];
            ren_nxt[s].prs      = i_prs[s];
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ren_vld <= '0;
        end else if (i_squash) begin
            ren_vld <= '0;
        end else if (!i_stall) begin
            ren_vld <= can_rename ? i_dec_vld : '0;  // Bubble when out of registers.
        end
    end

    // Payload holds while dispatch stalls.
    always_ff @(posedge clk) begin
        if (accept) begin
            ren_uop <= ren_nxt;
        end
    end

    assign o_ren_vld = ren_vld;
    assign o_ren_uop = ren_uop;

endmodule

`default_nettype wire

// ==== hdl/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_top (
    input  wire                                             clk,
    input  wire                                             i_arst_n,
    input  wire  [`RN_WIDTH-1:0]                            i_dec_vld,
    input  wire  rename_pkg::dec_uop_t [`RN_WIDTH-1:0]      i_dec_uop,
    output wire                                             o_stall,
    input  wire                                             i_stall,
    output wire  [`RN_WIDTH-1:0]                            o_ren_vld,
    output wire  rename_pkg::renamed_uop_t [`RN_WIDTH-1:0]  o_ren_uop,
    input  wire  [`RN_COMMIT_WIDTH-1:0]                     i_commit_vld,
    input  wire  rename_pkg::commit_info_t [`RN_COMMIT_WIDTH-1:0] i_commit_info,
    input  wire                                             i_squash
);
    wire                                                can_alloc;
    wire [`RN_WIDTH-1:0]                                alloc;
    wire rename_pkg::lreg_t [`RN_WIDTH-1:0]             lrd;
    wire rename_pkg::lreg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] lrs;
    wire rename_pkg::preg_t [`RN_WIDTH-1:0]             alloc_prd;
    wire rename_pkg::preg_t [`RN_WIDTH-1:0]             prev_prd;
    wire rename_pkg::preg_t [`RN_WIDTH-1:0][`RN_NUM_SRCS-1:0] prs;

    rename_stage u_stage (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_dec_vld   (i_dec_vld),
        .i_dec_uop   (i_dec_uop),
        .i_stall     (i_stall),
        .i_squash    (i_squash),
        .i_can_alloc (can_alloc),
        .i_new_prd   (alloc_prd),
        .i_prev_prd  (prev_prd),
        .i_prs       (prs),
        .o_stall     (o_stall),
        .o_alloc     (alloc),
        .o_lrd       (lrd),
        .o_lrs       (lrs),
        .o_ren_vld   (o_ren_vld),
        .o_ren_uop   (o_ren_uop)
    );

    rename_map_table u_map_table (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc       (alloc),
        .i_lrd         (lrd),
        .i_new_prd     (alloc_prd),
        .i_lrs         (lrs),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_squash      (i_squash),
        .o_prev_prd    (prev_prd),
        .o_prs         (prs)
    );

    rename_free_list u_free_list (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_alloc       (alloc),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_squash      (i_squash),
        .o_alloc_prd   (alloc_prd),
        .o_can_alloc   (can_alloc)
    );

endmodule

`default_nettype wire

// ==== verification/rename_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_asserts #(
    parameter bit STAGE_SIDE = 1'b1  // Stage checks, else the free-count check.
) (
    input wire                    clk,
    input wire                    i_arst_n,
    input wire                    i_squash,
    input wire                    i_stall,
    input wire [`RN_WIDTH-1:0]    i_alloc,
    input wire [`RN_WIDTH-1:0]    i_ren_vld,
    input wire [`RN_FL_PTR_W-1:0] i_free_cnt
);
    int fail_cnt = 0;  // Failed assertions.

    generate
        if (STAGE_SIDE) begin : g_stage
            a_squash_clears_vld: assert property (
                @(posedge clk) disable iff (!i_arst_n) i_squash |=> (i_ren_vld == '0)
            ) else begin
                fail_cnt++;
                $error("o_ren_vld set in the cycle after a squash");
            end

            a_no_alloc_in_stall: assert property (
                @(posedge clk) disable iff (!i_arst_n) i_stall |-> (i_alloc == '0)
            ) else begin
                fail_cnt++;
                $error("registers allocated while dispatch stalls");
            end
        end else begin : g_free_list
            a_free_cnt_bound: assert property (
                @(posedge clk) disable iff (!i_arst_n) i_free_cnt <= `RN_FL_DEPTH
            ) else begin
                fail_cnt++;
                $error("free count above the free-list depth");
            end
        end
    endgenerate

endmodule

// Squash and stall checks on the stage outputs.
bind rename_stage rename_asserts #(.STAGE_SIDE(1'b1)) u_stage_asserts (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_squash   (i_squash),
    .i_stall    (i_stall),
    .i_alloc    (o_alloc),
    .i_ren_vld  (o_ren_vld),
    .i_free_cnt ('0)
);

// Occupancy check on the free list.
bind rename_free_list rename_asserts #(.STAGE_SIDE(1'b0)) u_fl_asserts (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_squash   (i_squash),
    .i_stall    (1'b0),
    .i_alloc    (i_alloc),
    .i_ren_vld  ('0),
    .i_free_cnt (free_cnt)
);

`default_nettype wire

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_defines.svh"

module rename_tb;
    localparam int MAX_CYCLES = 2000;

    logic                                            clk;
    logic                                            i_arst_n;
    logic [`RN_WIDTH-1:0]                            i_dec_vld;
    rename_pkg::dec_uop_t [`RN_WIDTH-1:0]            i_dec_uop;
    logic                                            o_stall;
    logic                                            i_stall;
    logic [`RN_WIDTH-1:0]                            o_ren_vld;
    rename_pkg::renamed_uop_t [`RN_WIDTH-1:0]        o_ren_uop;
    logic [`RN_COMMIT_WIDTH-1:0]                     i_commit_vld;
    rename_pkg::commit_info_t [`RN_COMMIT_WIDTH-1:0] i_commit_info;
    logic                                            i_squash;

    // Reference model of the tables, the free list and the dispatch register.
    rename_pkg::preg_t ref_spec [`RN_NUM_LREG];
    rename_pkg::preg_t ref_cmt  [`RN_NUM_LREG];
    rename_pkg::preg_t fl_q [$];               // From committed head to tail.
    int                spec_taken;             // Handed out past the committed head.
    rename_pkg::commit_info_t inflight [$];    // Renamed writers in program order.
    logic [`RN_WIDTH-1:0]                     exp_vld;
    rename_pkg::renamed_uop_t [`RN_WIDTH-1:0] exp_uop;

    integer seed = 76;
    int     cycles = 0;
    int     ok_cnt = 0;
    int     err_cnt = 0;

    rename_top uut (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_dec_vld     (i_dec_vld),
        .i_dec_uop     (i_dec_uop),
        .o_stall       (o_stall),
        .i_stall       (i_stall),
        .o_ren_vld     (o_ren_vld),
        .o_ren_uop     (o_ren_uop),
        .i_commit_vld  (i_commit_vld),
        .i_commit_info (i_commit_info),
        .i_squash      (i_squash)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
        if (act !== exp) begin
            $display("** Error at %0d ns: %s = %0d, expected %0d", $time, name, act, exp);
            err_cnt++;
        end else begin
            ok_cnt++;
        end
    endtask

    function automatic rename_pkg::dec_uop_t make_uop(input int tag, input bit wen,
                                                      input int lrd, input int rs0, input int rs1);
        rename_pkg::dec_uop_t u;
        u.tag    = 8'(tag);
        u.rd_wen = wen;
        u.lrd    = rename_pkg::lreg_t'(lrd);
        u.lrs[0] = rename_pkg::lreg_t'(rs0);
        u.lrs[1] = rename_pkg::lreg_t'(rs1);
        return u;
    endfunction

    function automatic rename_pkg::dec_uop_t rand_uop(input int tag);
        int r [3];
        for (int i = 0; i < 3; i++) begin
            r[i] = 1 + ($unsigned($random(seed)) % (`RN_NUM_LREG - 1));  // Never r0.
        end
        return make_uop(tag, 1'b1, r[0], r[1], r[2]);
    endfunction

    // Drives one clock of decode, commit and squash traffic and checks the registered result.
    task automatic run_cycle(input logic [`RN_WIDTH-1:0] vld, input rename_pkg::dec_uop_t u0,
                             input rename_pkg::dec_uop_t u1, input int n_cmt, input bit squash);
        bit                       can;
        bit                       accept;
        rename_pkg::renamed_uop_t r;
        rename_pkg::commit_info_t ci;
        i_dec_vld    = vld;
        i_dec_uop[0] = u0;
        i_dec_uop[1] = u1;
        i_squash     = squash;
        i_commit_vld = '0;
        for (int c = 0; c < n_cmt && inflight.size() > 0; c++) begin
            i_commit_vld[c]  = 1'b1;
            i_commit_info[c] = inflight.pop_front();
        end
        can    = (fl_q.size() - spec_taken) >= `RN_WIDTH;
        accept = can && !i_stall && !squash;
        #1;
        check_val("o_stall", o_stall, !can || i_stall);
        if (squash) begin
            exp_vld = '0;
        end else if (!i_stall) begin
            exp_vld = can ? vld : '0;
        end
        if (accept) begin
            // Slots are renamed one after the other, as in program order.
            for (int s = 0; s < `RN_WIDTH; s++) begin
                r.tag      = i_dec_uop[s].tag;
                r.rd_wen   = i_dec_uop[s].rd_wen;
                r.lrd      = i_dec_uop[s].lrd;
                r.prev_prd = ref_spec[i_dec_uop[s].lrd];
                for (int k = 0; k < `RN_NUM_SRCS; k++) begin
                    r.prs[k] = ref_spec[i_dec_uop[s].lrs[k]];
                end
                r.prd = '0;
                if (vld[s] && i_dec_uop[s].rd_wen && i_dec_uop[s].lrd != 0) begin
                    r.prd = fl_q[spec_taken];
                    spec_taken++;
                    ref_spec[r.lrd] = r.prd;
                    ci.rd_wen   = 1'b1;
                    ci.lrd      = r.lrd;
                    ci.prd      = r.prd;
                    ci.prev_prd = r.prev_prd;
                    inflight.push_back(ci);
                end
                exp_uop[s] = r;
            end
        end
        for (int c = 0; c < `RN_COMMIT_WIDTH; c++) begin
            if (i_commit_vld[c]) begin
                ref_cmt[i_commit_info[c].lrd] = i_commit_info[c].prd;
                fl_q.push_back(i_commit_info[c].prev_prd);
                void'(fl_q.pop_front());
                spec_taken--;
            end
        end
        if (squash) begin
            ref_spec   = ref_cmt;
            spec_taken = 0;
            inflight.delete();
        end
        @(posedge clk);
        #1;
        i_dec_vld    = '0;
        i_squash     = 1'b0;
        i_commit_vld = '0;
        check_val("o_ren_vld", o_ren_vld, exp_vld);
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (exp_vld[s]) begin
                check_val($sformatf("o_ren_uop[%0d].tag", s), o_ren_uop[s].tag, exp_uop[s].tag);
                check_val($sformatf("o_ren_uop[%0d].rd_wen", s), o_ren_uop[s].rd_wen,
                          exp_uop[s].rd_wen);
                check_val($sformatf("o_ren_uop[%0d].lrd", s), o_ren_uop[s].lrd, exp_uop[s].lrd);
                check_val($sformatf("o_ren_uop[%0d].prd", s), o_ren_uop[s].prd, exp_uop[s].prd);
                check_val($sformatf("o_ren_uop[%0d].prev_prd", s), o_ren_uop[s].prev_prd,
                          exp_uop[s].prev_prd);
                check_val($sformatf("o_ren_uop[%0d].prs", s), o_ren_uop[s].prs, exp_uop[s].prs);
            end
        end
    endtask

    task automatic drain_commits();
        while (inflight.size() > 0) begin
            run_cycle('0, '0, '0, `RN_COMMIT_WIDTH, 1'b0);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("Test %s passed", name);
        end else begin
            $display("Test %s failed with %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_reset_mapping();
        int f;
        f = err_cnt;
        check_val("o_ren_vld", o_ren_vld, 0);
        run_cycle(2'b11, make_uop(1, 1, 3, 1, 2), make_uop(2, 1, 5, 4, 6), 0, 0);
        check_val("o_ren_uop[0].prd", o_ren_uop[0].prd, 32);
        check_val("o_ren_uop[1].prd", o_ren_uop[1].prd, 33);
        end_test("reset_mapping", f);
    endtask

    task automatic test_intra_group();
        int f;
        f = err_cnt;
        run_cycle(2'b11, make_uop(3, 1, 7, 1, 2), make_uop(4, 1, 7, 7, 7), 0, 0);
        // Slot 1 is a writer but not valid.
        run_cycle(2'b01, make_uop(5, 1, 8, 7, 0), make_uop(6, 1, 9, 7, 8), 0, 0);
        end_test("intra_group", f);
    endtask

    task automatic test_exhaustion();
        int f;
        f = err_cnt;
        drain_commits();
        for (int g = 0; g < `RN_FL_DEPTH / 2; g++) begin
            run_cycle(2'b11, rand_uop(16 + 2 * g), rand_uop(17 + 2 * g), 0, 0);
        end
        repeat (2) run_cycle(2'b11, rand_uop(80), rand_uop(81), 0, 0);  // Refused.
        run_cycle('0, '0, '0, 2, 0);
        run_cycle(2'b11, rand_uop(82), rand_uop(83), 0, 0);  // Takes the freed registers.
        drain_commits();
        end_test("exhaustion", f);
    endtask

    task automatic test_back_pressure();
        int f;
        f = err_cnt;
        run_cycle(2'b11, rand_uop(90), rand_uop(91), 0, 0);
        i_stall = 1'b1;
        repeat (3) run_cycle(2'b11, rand_uop(92), rand_uop(93), 0, 0);
        i_stall = 1'b0;
        run_cycle(2'b11, rand_uop(94), rand_uop(95), 0, 0);
        drain_commits();
        end_test("back_pressure", f);
    endtask

    task automatic test_squash();
        int f;
        f = err_cnt;
        for (int g = 0; g < 3; g++) begin
            run_cycle(2'b11, make_uop(100 + g, 1, 10 + 2 * g, 9 + 2 * g, 1),
                      make_uop(110 + g, 1, 11 + 2 * g, 10 + 2 * g, 2), 0, 0);
        end
        // The first group commits in the squash cycle itself.
        run_cycle(2'b11, rand_uop(120), rand_uop(121), 2, 1);
        run_cycle(2'b11, make_uop(122, 1, 20, 10, 11), make_uop(123, 1, 21, 12, 13), 0, 0);
        drain_commits();
        end_test("squash", f);
    endtask

    task automatic test_reg_zero();
        int f;
        f = err_cnt;
        run_cycle(2'b11, make_uop(60, 1, 0, 1, 0), make_uop(61, 1, 9, 0, 9), 0, 0);
        check_val("o_ren_uop[0].prd", o_ren_uop[0].prd, 0);
        // Slot 1 has no destination write.
        run_cycle(2'b11, make_uop(62, 1, 4, 9, 0), make_uop(63, 0, 5, 4, 9), 0, 0);
        drain_commits();
        end_test("reg_zero", f);
    endtask

    initial begin
        int total_err;
        i_arst_n      = 1'b0;
        i_dec_vld     = '0;
        i_dec_uop     = '0;
        i_stall       = 1'b0;
        i_commit_vld  = '0;
        i_commit_info = '0;
        i_squash      = 1'b0;
        for (int l = 0; l < `RN_NUM_LREG; l++) begin
            ref_spec[l] = rename_pkg::preg_t'(l);
            ref_cmt[l]  = rename_pkg::preg_t'(l);
        end
        for (int e = 0; e < `RN_FL_DEPTH; e++) begin
            fl_q.push_back(rename_pkg::preg_t'(`RN_NUM_LREG + e));
        end
        spec_taken = 0;
        exp_vld    = '0;
        repeat (3) @(posedge clk);
        #1;
        i_arst_n = 1'b1;
        test_reset_mapping();
        test_intra_group();
        test_exhaustion();
        test_back_pressure();
        test_squash();
        test_reg_zero();
        total_err = err_cnt + uut.u_stage.u_stage_asserts.fail_cnt +
                    uut.u_free_list.u_fl_asserts.fail_cnt;
        $display("Checks passed: %0d, failed: %0d", ok_cnt, total_err);
        if (total_err == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+include
hdl/rename_pkg.sv
hdl/rename_free_list.sv
hdl/rename_map_table.sv
hdl/rename_stage.sv
hdl/rename_top.sv
verification/rename_asserts.sv
verification/rename_tb.sv

// ==== Bender.yml ====
package:
  name: rename

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/rename_pkg.sv
      - hdl/rename_free_list.sv
      - hdl/rename_map_table.sv
      - hdl/rename_stage.sv
      - hdl/rename_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/rename_asserts.sv
      - verification/rename_tb.sv
